// ==== sources.f ====
rtl/csr_pkg.sv
rtl/sys_pipe_pkg.sv
rtl/sys_delay_line.sv
rtl/sys_exc_tracker.sv
rtl/sys_csr_file.sv
rtl/sys_pipe_top.sv
dv/sys_pipe_tb.sv

// ==== Makefile ====
# Verilator flow for the system pipe testbench

TOP := sys_pipe_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -Wno-fatal --top-module $(TOP) -f sources.f

# The run passes only if the log holds the pass message
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/sys_pipe_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the system pipe: CSR operations,
// traps, TLB misses, flush and instret
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sys_pipe_tb;

  localparam int data_width_lp  = 64;
  localparam int vaddr_width_lp = 39;
  localparam int timeout_lp     = 16;

  logic                        clk;
  logic                        rst_n;
  logic                        dispatch_v;
  sys_pipe_pkg::sys_dispatch_s dispatch;
  logic [vaddr_width_lp-1:0]   dispatch_pc;
  logic [data_width_lp-1:0]    rs1;
  logic                        flush;
  logic                        dtlb_miss;
  sys_pipe_pkg::mem_fault_s    mem_fault;
  logic [vaddr_width_lp-1:0]   fault_vaddr;
  logic                        commit_v;
  csr_pkg::commit_s            commit;
  logic [vaddr_width_lp-1:0]   commit_pc;
  logic [data_width_lp-1:0]    csr_data;

  integer                      seed = 32'h1fe309ee;
  int                          error_count;
  int                          check_count;
  int                          clean_count;
  logic [data_width_lp-1:0]    mscratch_model;
  logic [vaddr_width_lp-1:0]   next_pc;
  logic [vaddr_width_lp-1:0]   last_pc;
  csr_pkg::commit_s            clean_exp;
  csr_pkg::commit_s            illegal_exp;

  sys_pipe_top
    #(.data_width_p(data_width_lp)
    , .vaddr_width_p(vaddr_width_lp)
    )
  UUT
    (.clk_i(clk)
    , .rst_n_i(rst_n)
    , .dispatch_v_i(dispatch_v)
    , .dispatch_i(dispatch)
    , .dispatch_pc_i(dispatch_pc)
    , .rs1_i(rs1)
    , .flush_i(flush)
    , .dtlb_miss_i(dtlb_miss)
    , .mem_fault_i(mem_fault)
    , .fault_vaddr_i(fault_vaddr)
    , .commit_v_o(commit_v)
    , .commit_o(commit)
    , .commit_pc_o(commit_pc)
    , .csr_data_o(csr_data)
    );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_equal(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic csr_pkg::commit_s make_commit(input logic instret, input logic exception,
                                                   input logic [3:0] cause,
                                                   input logic [2:0] miss);
    csr_pkg::commit_s c;
    c.instret    = instret;
    c.exception  = exception;
    c.cause      = csr_pkg::cause_e'(cause);
    // Miss bits ordered instr, load, store
    c.instr_miss = miss[2];
    c.load_miss  = miss[1];
    c.store_miss = miss[0];
    return c;
  endfunction

  function automatic sys_pipe_pkg::sys_dispatch_s csr_cmd(input csr_pkg::csr_op_e op,
                                                          input logic [11:0] addr,
                                                          input logic [4:0] zimm);
    sys_pipe_pkg::sys_dispatch_s d;
    d          = '0;
    d.csr_v    = 1'b1;
    d.csr_op   = op;
    d.csr_addr = addr;
    d.zimm     = zimm;
    return d;
  endfunction

  function automatic sys_pipe_pkg::sys_dispatch_s mem_cmd(input logic is_store,
                                                          input logic itlb);
    sys_pipe_pkg::sys_dispatch_s d;
    d           = '0;
    d.mem_v     = 1'b1;
    d.is_store  = is_store;
    d.itlb_miss = itlb;
    return d;
  endfunction

  // Dispatch one instruction, feed stage faults, then wait for its commit
  task automatic execute_instr(input sys_pipe_pkg::sys_dispatch_s cmd,
                               input logic [63:0] opnd, input logic dtlb,
                               input sys_pipe_pkg::mem_fault_s fault,
                               input logic [vaddr_width_lp-1:0] vaddr,
                               input csr_pkg::commit_s exp_commit,
                               input logic [63:0] exp_data);
    int   latency;
    logic found;
    @(posedge clk);
    dispatch_v  <= 1'b1;
    dispatch    <= cmd;
    dispatch_pc <= next_pc;
    rs1         <= opnd;
    last_pc      = next_pc;
    next_pc      = next_pc + 4;
    @(posedge clk);
    dispatch_v <= 1'b0;
    dispatch   <= '0;
    dtlb_miss  <= dtlb;
    @(posedge clk);
    dtlb_miss   <= 1'b0;
    mem_fault   <= fault;
    fault_vaddr <= vaddr;
    latency = 2;
    found   = 1'b0;
    while (!found && latency < timeout_lp)
    begin
      @(negedge clk);
      if (commit_v)
        found = 1'b1;
      else
        latency++;
    end
    if (found)
    begin
      check_equal("commit latency", 64'(latency), 64'd2);
      check_equal("commit packet", 64'(commit), 64'(exp_commit));
      check_equal("csr data", csr_data, exp_data);
      check_equal("commit pc", 64'(commit_pc), 64'(last_pc));
      if (exp_commit.instret)
        clean_count++;
    end
    else
    begin
      error_count++;
      $display("No commit arrived within %0d cycles of dispatch at %0t ns", timeout_lp, $time);
    end
    @(posedge clk);
    mem_fault   <= '0;
    fault_vaddr <= '0;
  endtask

  task automatic run_csr(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                         input logic [4:0] zimm, input logic [63:0] opnd,
                         input csr_pkg::commit_s exp_commit, input logic [63:0] exp_data);
    execute_instr(csr_cmd(op, addr, zimm), opnd, 1'b0, '0, '0, exp_commit, exp_data);
  endtask

  task automatic csr_read_write();
    logic [63:0] opnd;
    opnd = rand64();
    run_csr(csr_pkg::csr_rw, csr_pkg::csr_mscratch, 5'd0, opnd, clean_exp, mscratch_model);
    mscratch_model = opnd;
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mscratch, 5'd0, 64'd0, clean_exp, mscratch_model);
  endtask

  task automatic csr_set_clear();
    logic [63:0] mask;
    mask = rand64();
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mscratch, 5'd0, mask, clean_exp, mscratch_model);
    mscratch_model = mscratch_model | mask;
    mask = rand64();
    run_csr(csr_pkg::csr_rc, csr_pkg::csr_mscratch, 5'd0, mask, clean_exp, mscratch_model);
    mscratch_model = mscratch_model & ~mask;
    // Immediate forms ignore rs1
    run_csr(csr_pkg::csr_rwi, csr_pkg::csr_mscratch, 5'h15, rand64(), clean_exp,
            mscratch_model);
    mscratch_model = 64'h15;
    run_csr(csr_pkg::csr_rsi, csr_pkg::csr_mscratch, 5'h0a, 64'd0, clean_exp, mscratch_model);
    mscratch_model = mscratch_model | 64'h0a;
    run_csr(csr_pkg::csr_rci, csr_pkg::csr_mscratch, 5'h03, 64'd0, clean_exp, mscratch_model);
    mscratch_model = mscratch_model & ~64'h03;
    run_csr(csr_pkg::csr_rw, 12'h7ff, 5'd0, rand64(), illegal_exp, 64'd0);
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mscratch, 5'd0, 64'd0, clean_exp, mscratch_model);
  endtask

  task automatic mem_fault_traps();
    sys_pipe_pkg::mem_fault_s  fault;
    logic [vaddr_width_lp-1:0] vaddr;
    logic [vaddr_width_lp-1:0] trap_pc;
    vaddr = vaddr_width_lp'(rand64());
    fault = '0;
    fault.load_page_fault = 1'b1;
    execute_instr(mem_cmd(1'b0, 1'b0), 64'd0, 1'b0, fault, vaddr,
                  make_commit(1'b0, 1'b1, 4'd13, 3'b000), 64'd0);
    trap_pc = last_pc;
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mepc, 5'd0, 64'd0, clean_exp, 64'(trap_pc));
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mcause, 5'd0, 64'd0, clean_exp, 64'd13);
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mtval, 5'd0, 64'd0, clean_exp, 64'(vaddr));
    // Load access fault outranks store misaligned and blocks the csrrw
    fault = '0;
    fault.load_access_fault = 1'b1;
    fault.store_misaligned  = 1'b1;
    execute_instr(csr_cmd(csr_pkg::csr_rw, csr_pkg::csr_mscratch, 5'd0), rand64(), 1'b0,
                  fault, vaddr, make_commit(1'b0, 1'b1, 4'd5, 3'b000), mscratch_model);
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mcause, 5'd0, 64'd0, clean_exp, 64'd5);
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mscratch, 5'd0, 64'd0, clean_exp, mscratch_model);
  endtask

  task automatic tlb_miss_reports();
    execute_instr(mem_cmd(1'b0, 1'b0), 64'd0, 1'b1, '0, '0,
                  make_commit(1'b0, 1'b0, 4'd0, 3'b010), 64'd0);
    execute_instr(mem_cmd(1'b1, 1'b0), 64'd0, 1'b1, '0, '0,
                  make_commit(1'b0, 1'b0, 4'd0, 3'b001), 64'd0);
    execute_instr(mem_cmd(1'b0, 1'b1), 64'd0, 1'b0, '0, '0,
                  make_commit(1'b0, 1'b0, 4'd0, 3'b100), 64'd0);
  endtask

  task automatic flush_and_instret();
    logic seen;
    for (int i = 0; i < 3; i++)
    begin
      @(posedge clk);
      dispatch_v  <= 1'b1;
      dispatch    <= csr_cmd(csr_pkg::csr_rw, csr_pkg::csr_mscratch, 5'd0);
      dispatch_pc <= next_pc;
      rs1         <= rand64();
      next_pc      = next_pc + 4;
    end
    // Oldest at commit, one in stage 1, one being dispatched
    flush <= 1'b1;
    @(negedge clk);
    seen = commit_v;
    @(posedge clk);
    dispatch_v <= 1'b0;
    dispatch   <= '0;
    flush      <= 1'b0;
    repeat (5)
    begin
      @(negedge clk);
      seen = seen | commit_v;
    end
    check_count++;
    if (seen)
    begin
      error_count++;
      $display("A flushed instruction still committed, seen at %0t ns", $time);
    end
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_mscratch, 5'd0, 64'd0, clean_exp, mscratch_model);
    run_csr(csr_pkg::csr_rs, csr_pkg::csr_minstret, 5'd0, 64'd0, clean_exp,
            64'(clean_count));
  endtask

  initial
  begin
    rst_n          = 1'b0;
    dispatch_v     = 1'b0;
    dispatch       = '0;
    dispatch_pc    = '0;
    rs1            = '0;
    flush          = 1'b0;
    dtlb_miss      = 1'b0;
    mem_fault      = '0;
    fault_vaddr    = '0;
    error_count    = 0;
    check_count    = 0;
    clean_count    = 0;
    mscratch_model = '0;
    next_pc        = 39'h0_8000_0000;
    last_pc        = '0;
    clean_exp      = make_commit(1'b1, 1'b0, 4'd0, 3'b000);
    illegal_exp    = make_commit(1'b0, 1'b1, 4'd2, 3'b000);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    csr_read_write();
    csr_set_clear();
    mem_fault_traps();
    tlb_miss_reports();
    flush_and_instret();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== rtl/sys_pipe_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System pipe top: dispatch to commit in two stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sys_pipe_top
  #(parameter int data_width_p  = 64
  , parameter int vaddr_width_p = 39
  )
  (input  logic                          clk_i
  , input  logic                          rst_n_i
  , input  logic                          dispatch_v_i
  , input  sys_pipe_pkg::sys_dispatch_s   dispatch_i
  , input  logic [vaddr_width_p-1:0]      dispatch_pc_i
  , input  logic [data_width_p-1:0]       rs1_i
  , input  logic                          flush_i
  , input  logic                          dtlb_miss_i
  , input  sys_pipe_pkg::mem_fault_s      mem_fault_i
  , input  logic [vaddr_width_p-1:0]      fault_vaddr_i
  , output logic                          commit_v_o
  , output csr_pkg::commit_s              commit_o
  , output logic [vaddr_width_p-1:0]      commit_pc_o
  , output logic [data_width_p-1:0]       csr_data_o
  );

  sys_pipe_pkg::sys_dispatch_s cmd_r;
  logic [data_width_p-1:0]     rs1_r;
  sys_pipe_pkg::sys_exc_s      exc;

  sys_delay_line
    #(.payload_t(sys_pipe_pkg::sys_dispatch_s)
    , .stages_p(sys_pipe_pkg::commit_stage_lp)
    )
  cmd_line
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .valid_i(dispatch_v_i)
    , .data_i(dispatch_i)
    , .valid_o()
    , .data_o(cmd_r)
    );

  sys_delay_line
    #(.payload_t(logic [vaddr_width_p-1:0])
    , .stages_p(sys_pipe_pkg::commit_stage_lp)
    )
  pc_line
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .valid_i(dispatch_v_i)
    , .data_i(dispatch_pc_i)
    , .valid_o()
    , .data_o(commit_pc_o)
    );

  sys_delay_line
    #(.payload_t(logic [data_width_p-1:0])
    , .stages_p(sys_pipe_pkg::commit_stage_lp)
    )
  opnd_line
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .valid_i(dispatch_v_i)
    , .data_i(rs1_i)
    , .valid_o()
    , .data_o(rs1_r)
    );

  sys_exc_tracker tracker
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .dispatch_v_i(dispatch_v_i)
    , .itlb_miss_i(dispatch_i.itlb_miss)
    , .illegal_instr_i(dispatch_i.illegal_instr)
    , .dtlb_miss_i(dtlb_miss_i)
    , .flush_i(flush_i)
    , .commit_v_o(commit_v_o)
    , .exc_o(exc)
    );

  sys_csr_file
    #(.data_width_p(data_width_p)
    , .vaddr_width_p(vaddr_width_p)
    )
  csr_file
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .commit_v_i(commit_v_o)
    , .exc_i(exc)
    , .cmd_i(cmd_r)
    , .rs1_i(rs1_r)
    , .pc_i(commit_pc_o)
    , .mem_fault_i(mem_fault_i)
    , .fault_vaddr_i(fault_vaddr_i)
    , .commit_o(commit_o)
    , .csr_data_o(csr_data_o)
    );

endmodule

// ==== rtl/sys_csr_file.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine CSRs with commit decision, trap capture and the
// instret counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sys_csr_file
  #(parameter int data_width_p  = 64
  , parameter int vaddr_width_p = 39
  )
  (input  logic                          clk_i
  , input  logic                          rst_n_i
  , input  logic                          commit_v_i
  , input  sys_pipe_pkg::sys_exc_s        exc_i
  , input  sys_pipe_pkg::sys_dispatch_s   cmd_i
  , input  logic [data_width_p-1:0]       rs1_i
  , input  logic [vaddr_width_p-1:0]      pc_i
  , input  sys_pipe_pkg::mem_fault_s      mem_fault_i
  , input  logic [vaddr_width_p-1:0]      fault_vaddr_i
  , output csr_pkg::commit_s              commit_o
  , output logic [data_width_p-1:0]       csr_data_o
  );

  logic [data_width_p-1:0] mscratch_r, mepc_r, mcause_r, mtval_r, minstret_r;
  logic [data_width_p-1:0] opnd, rdata, wdata;
  sys_pipe_pkg::sys_exc_s  exc;
  csr_pkg::cause_e         cause;
  logic                    addr_ok, illegal, mem_fault, any_miss;
  logic                    trap_v, clean_v, csr_we, instret_we;

  always_comb
  begin
    exc       = exc_i;
    exc.mem   = exc_i.mem | mem_fault_i;
    addr_ok   = cmd_i.csr_addr inside {csr_pkg::csr_mscratch, csr_pkg::csr_mepc,
                                       csr_pkg::csr_mcause, csr_pkg::csr_mtval,
                                       csr_pkg::csr_minstret};
    illegal   = exc.illegal_instr | (cmd_i.csr_v & ~addr_ok);
    mem_fault = |exc.mem;
    any_miss  = exc.itlb_miss | exc.dtlb_miss;
    // A TLB miss replays the instruction, so it hides any fault
    trap_v    = commit_v_i & ~any_miss & (illegal | mem_fault);
    clean_v   = commit_v_i & ~any_miss & ~illegal & ~mem_fault;

    if (illegal)                     cause = csr_pkg::cause_illegal_instr;
    else if (exc.mem.load_misaligned)    cause = csr_pkg::cause_load_misaligned;
    else if (exc.mem.load_access_fault)  cause = csr_pkg::cause_load_access_fault;
    else if (exc.mem.load_page_fault)    cause = csr_pkg::cause_load_page_fault;
    else if (exc.mem.store_misaligned)   cause = csr_pkg::cause_store_misaligned;
    else if (exc.mem.store_access_fault) cause = csr_pkg::cause_store_access_fault;
    else if (exc.mem.store_page_fault)   cause = csr_pkg::cause_store_page_fault;
    else                                 cause = csr_pkg::cause_e'(4'd0);

    commit_o.instret    = clean_v;
    commit_o.exception  = trap_v;
    commit_o.cause      = trap_v ? cause : csr_pkg::cause_e'(4'd0);
    commit_o.instr_miss = commit_v_i & exc.itlb_miss;
    commit_o.load_miss  = commit_v_i & exc.dtlb_miss & ~cmd_i.is_store;
    commit_o.store_miss = commit_v_i & exc.dtlb_miss & cmd_i.is_store;
  end

  always_comb
  begin
    case (cmd_i.csr_addr)
      csr_pkg::csr_mscratch: rdata = mscratch_r;
      csr_pkg::csr_mepc:     rdata = mepc_r;
      csr_pkg::csr_mcause:   rdata = mcause_r;
      csr_pkg::csr_mtval:    rdata = mtval_r;
      csr_pkg::csr_minstret: rdata = minstret_r;
      default:               rdata = '0;
    endcase

    if (cmd_i.csr_op inside {csr_pkg::csr_rwi, csr_pkg::csr_rsi, csr_pkg::csr_rci})
      opnd = data_width_p'(cmd_i.zimm);
    else
      opnd = rs1_i;

    case (cmd_i.csr_op)
      csr_pkg::csr_rw, csr_pkg::csr_rwi: wdata = opnd;
      csr_pkg::csr_rs, csr_pkg::csr_rsi: wdata = rdata | opnd;
      csr_pkg::csr_rc, csr_pkg::csr_rci: wdata = rdata & ~opnd;
      default:                           wdata = rdata;
    endcase

    // Set and clear with a zero operand leave the CSR alone
    csr_we     = clean_v & cmd_i.csr_v
               & ((cmd_i.csr_op inside {csr_pkg::csr_rw, csr_pkg::csr_rwi}) | (|opnd));
    instret_we = csr_we & (cmd_i.csr_addr == csr_pkg::csr_minstret);
  end

  assign csr_data_o = rdata;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mscratch_r <= '0;
      mepc_r     <= '0;
      mcause_r   <= '0;
      mtval_r    <= '0;
      minstret_r <= '0;
    end
    else
    begin
      if (trap_v)
      begin
        mepc_r   <= data_width_p'(pc_i);
        mcause_r <= data_width_p'(cause);
        mtval_r  <= mem_fault ? data_width_p'(fault_vaddr_i) : '0;
      end
      else if (csr_we)
      begin
        case (cmd_i.csr_addr)
          csr_pkg::csr_mscratch: mscratch_r <= wdata;
          csr_pkg::csr_mepc:     mepc_r     <= wdata;
          csr_pkg::csr_mcause:   mcause_r   <= wdata;
          csr_pkg::csr_mtval:    mtval_r    <= wdata;
          default:               ;
        endcase
      end

      // An explicit write replaces the count
      if (instret_we)
        minstret_r <= wdata;
      else if (clean_v)
        minstret_r <= minstret_r + 1'b1;
    end
  end

  a_quiet_without_commit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !commit_v_i |=> $stable(mscratch_r) && $stable(mepc_r) && $stable(mcause_r)
                    && $stable(mtval_r) && $stable(minstret_r));

endmodule

// ==== rtl/sys_exc_tracker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-stage valid, poison and fault tracking from dispatch
// up to the commit point
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sys_exc_tracker
  (input  logic                   clk_i
  , input  logic                   rst_n_i
  , input  logic                   dispatch_v_i
  , input  logic                   itlb_miss_i
  , input  logic                   illegal_instr_i
  , input  logic                   dtlb_miss_i
  , input  logic                   flush_i
  , output logic                   commit_v_o
  , output sys_pipe_pkg::sys_exc_s exc_o
  );

  localparam int last_lp = sys_pipe_pkg::commit_stage_lp;

  logic [last_lp:1]       valid_r;
  logic [last_lp:1]       poison_r;
  sys_pipe_pkg::sys_exc_s exc_r [1:last_lp];
  sys_pipe_pkg::sys_exc_s exc_entry;
  sys_pipe_pkg::sys_exc_s exc_s1;

  always_comb
  begin
    exc_entry               = '0;
    exc_entry.itlb_miss     = itlb_miss_i;
    exc_entry.illegal_instr = illegal_instr_i;
    // Data TLB answers while the instruction sits in stage 1
    exc_s1           = exc_r[1];
    exc_s1.dtlb_miss = exc_r[1].dtlb_miss | dtlb_miss_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_r  <= '0;
      poison_r <= '0;
    end
    else
    begin
      valid_r[1]  <= dispatch_v_i;
      poison_r[1] <= flush_i;
      for (int s = 2; s <= last_lp; s++)
      begin
        valid_r[s]  <= valid_r[s-1];
        poison_r[s] <= poison_r[s-1] | flush_i;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    exc_r[1] <= exc_entry;
    exc_r[2] <= exc_s1;
    for (int s = 3; s <= last_lp; s++)
    begin
      exc_r[s] <= exc_r[s-1];
    end
  end

  // Flush also kills the instruction at the commit point this cycle
  assign commit_v_o = valid_r[last_lp] & ~poison_r[last_lp] & ~flush_i;
  assign exc_o      = exc_r[last_lp];

  // Everything in flight at a flush must drain without committing
  a_flush_drains: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> !commit_v_o ##1 !commit_v_o ##1 !commit_v_o);

endmodule

// ==== rtl/sys_delay_line.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-latency delay line with a valid bit, generic payload
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sys_delay_line
  #(parameter type payload_t = logic
  , parameter int  stages_p  = 2
  )
  (input  logic     clk_i
  , input  logic     rst_n_i
  , input  logic     valid_i
  , input  payload_t data_i
  , output logic     valid_o
  , output payload_t data_o
  );

  logic [stages_p-1:0] valid_r;
  payload_t            data_r [stages_p];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_r <= '0;
    end
    else
    begin
      valid_r[0] <= valid_i;
      for (int i = 1; i < stages_p; i++)
      begin
        valid_r[i] <= valid_r[i-1];
      end
    end
  end

  // Payload shifts every cycle, qualified by valid at the far end
  always_ff @(posedge clk_i)
  begin
    data_r[0] <= data_i;
    for (int i = 1; i < stages_p; i++)
    begin
      data_r[i] <= data_r[i-1];
    end
  end

  assign valid_o = valid_r[stages_p-1];
  assign data_o  = data_r[stages_p-1];

  a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(valid_o));

endmodule

// ==== rtl/sys_pipe_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System pipe types: dispatch packet, memory-side fault
// flags and the per-instruction accumulated fault record
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sys_pipe_pkg;

  // Stage index of the commit point, counted from dispatch
  localparam int commit_stage_lp = 2;

  // Decoded fields dispatched with each instruction
  typedef struct packed {
    logic             csr_v;
    csr_pkg::csr_op_e csr_op;
    logic [11:0]      csr_addr;
    logic [4:0]       zimm;
    logic             mem_v;
    logic             is_store;
    // Front-end faults, already known at dispatch
    logic             itlb_miss;
    logic             illegal_instr;
  } sys_dispatch_s;

  // Memory side faults, reported in the commit stage
  typedef struct packed {
    logic load_misaligned;
    logic load_access_fault;
    logic load_page_fault;
    logic store_misaligned;
    logic store_access_fault;
    logic store_page_fault;
  } mem_fault_s;

  // Faults collected on one instruction as it moves down the pipe
  typedef struct packed {
    logic       itlb_miss;
    logic       illegal_instr;
    logic       dtlb_miss;
    mem_fault_s mem;
  } sys_exc_s;

endpackage

// ==== rtl/csr_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine CSR addresses, CSR op codes, trap causes and the
// commit packet reported at the end of the system pipe
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package csr_pkg;

  // Encoded as funct3, bit 2 marks the immediate forms
  typedef enum logic [2:0] {
    csr_rw  = 3'd1,
    csr_rs  = 3'd2,
    csr_rc  = 3'd3,
    csr_rwi = 3'd5,
    csr_rsi = 3'd6,
    csr_rci = 3'd7
  } csr_op_e;

  typedef enum logic [11:0] {
    csr_mscratch = 12'h340,
    csr_mepc     = 12'h341,
    csr_mcause   = 12'h342,
    csr_mtval    = 12'h343,
    csr_minstret = 12'hb02
  } csr_addr_e;

  typedef enum logic [3:0] {
    cause_illegal_instr      = 4'd2,
    cause_load_misaligned    = 4'd4,
    cause_load_access_fault  = 4'd5,
    cause_store_misaligned   = 4'd6,
    cause_store_access_fault = 4'd7,
    cause_load_page_fault    = 4'd13,
    cause_store_page_fault   = 4'd15
  } cause_e;

  typedef struct packed {
    logic   instret;
    logic   exception;
    cause_e cause;
    logic   instr_miss;
    logic   load_miss;
    logic   store_miss;
  } commit_s;

endpackage
